// File: hw/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

    // One byte as it leaves the receiver.
    typedef logic [7:0] scan_code_t;

    // Full PS/2 frame on the wire, bit 0 is the start bit and bit 10 the stop bit.
    // Bits 8:1 carry the byte LSB first, bit 9 is odd parity.
    typedef logic [10:0] frame_t;

    // Scan-code set 2 prefixes.
    localparam scan_code_t BREAK_PREFIX = 8'hF0; // Key released, code follows.
    localparam scan_code_t EXT_PREFIX   = 8'hE0; // Extended key, code follows.

endpackage

`default_nettype wire

// File: hw/disp_pkg.sv
`default_nettype none

package disp_pkg;

    typedef logic [3:0] hex_digit_t;

    // Bit order is {dp, g, f, e, d, c, b, a}, a zero lights the segment.
    typedef logic [7:0] seg_pattern_t;

    localparam seg_pattern_t SEG_BLANK = 8'hFF; // Everything dark.

endpackage

`default_nettype wire

// File: hw/ps2_byte_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ps2_byte_if
    import ps2_pkg::*;
();

    scan_code_t data;      // FIFO head.
    logic       ready;     // FIFO not empty.
    logic       pop;       // Removes the head at the next edge.
    logic       frame_err; // One cycle per rejected frame.

    modport source
    (
        output data,
        output ready,
        output frame_err,
        input  pop
    );

    modport sink
    (
        input  data,
        input  ready,
        input  frame_err,
        output pop
    );

endinterface

`default_nettype wire

// File: hw/seg7_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module seg7_decoder
    import disp_pkg::*;
(
    input  hex_digit_t   digit,
    input  logic         blank,
    output seg_pattern_t seg
);

    // Decimal point stays dark in every pattern.
    always_comb
    begin
        if (blank)
        begin
            seg = SEG_BLANK;
        end
        else
        begin
            case (digit)
                4'h0:    seg = 8'hC0;
                4'h1:    seg = 8'hF9;
                4'h2:    seg = 8'hA4;
                4'h3:    seg = 8'hB0;
                4'h4:    seg = 8'h99;
                4'h5:    seg = 8'h92;
                4'h6:    seg = 8'h82;
                4'h7:    seg = 8'hF8;
                4'h8:    seg = 8'h80;
                4'h9:    seg = 8'h90;
                4'hA:    seg = 8'h88;
                4'hB:    seg = 8'h83; // Lower-case b.
                4'hC:    seg = 8'hC6;
                4'hD:    seg = 8'hA1; // Lower-case d.
                4'hE:    seg = 8'h86;
                default: seg = 8'h8E;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/ps2_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_receiver
    import ps2_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
)
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    ps2_byte_if.source byte_if
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [2:0]  clk_q;
    logic [1:0]  dat_q;
    logic        fall;
    logic [3:0]  bit_cnt;
    frame_t      shift_q;
    frame_t      frame_next;
    logic        frame_end;
    logic        frame_good;
    logic        fifo_wr;
    logic        full;
    logic        empty;
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] fill;
    scan_code_t  mem [FIFO_DEPTH];

    // Both lines idle high.
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_q <= '1;
            dat_q <= '1;
        end
        else
        begin
            clk_q <= {clk_q[1:0], ps2_clk};
            dat_q <= {dat_q[0], ps2_dat};
        end
    end

    assign fall = clk_q[2] & ~clk_q[1]; // Device changes data on the rising edge.

    // Bits arrive LSB first, so they enter at the top and walk down.
    assign frame_next = {dat_q[1], shift_q[10:1]};
    assign frame_end  = fall && (bit_cnt == 4'd10);

    always_ff @(posedge clk)
    begin
        if (fall)
        begin
            shift_q <= frame_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_cnt <= '0;
        end
        else if (fall)
        begin
            bit_cnt <= frame_end ? 4'd0 : bit_cnt + 4'd1;
        end
    end

    // Start low, stop high, data plus parity odd.
    assign frame_good = !frame_next[0] && frame_next[10] && (^frame_next[9:1]);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            byte_if.frame_err <= 1'b0;
        end
        else
        begin
            byte_if.frame_err <= frame_end && !frame_good;
        end
    end

    // Circular FIFO. The extra pointer bit tells full from empty.
    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign fifo_wr = frame_end && frame_good && !full; // A full FIFO drops the byte.
    assign fill    = wr_ptr - rd_ptr; // Bytes held.

    always_ff @(posedge clk)
    begin
        if (fifo_wr)
        begin
            mem[wr_ptr[AW-1:0]] <= frame_next[8:1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (fifo_wr)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (byte_if.pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign byte_if.data  = mem[rd_ptr[AW-1:0]];
    assign byte_if.ready = !empty;

    // The tracker may only take a byte that is there.
    a_pop_needs_ready: assert property (@(posedge clk) disable iff (!rst)
        byte_if.pop |-> byte_if.ready);

    // A write into a full FIFO would hold more bytes than there are slots.
    a_no_write_full: assert property (@(posedge clk) disable iff (!rst)
        fill <= FIFO_DEPTH);

endmodule

`default_nettype wire

// File: hw/key_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module key_tracker
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    ps2_byte_if.sink   byte_if,
    output scan_code_t held_code,
    output logic       blank
);

    typedef enum logic [1:0]
    {
        st_idle,
        st_pop,
        st_wait_break
    } state_t;

    state_t state;
    logic   take_break;

    // After F0 the next byte is taken straight from the wait state.
    assign take_break  = (state == st_wait_break) && byte_if.ready && !byte_if.frame_err;
    assign byte_if.pop = (state == st_pop) || take_break;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state     <= st_idle;
            held_code <= '0;
            blank     <= 1'b1;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (byte_if.ready)
                    begin
                        state <= st_pop;
                    end
                end
                st_pop:
                begin
                    if (byte_if.data == BREAK_PREFIX)
                    begin
                        state <= st_wait_break;
                    end
                    else
                    begin
                        state <= st_idle;
                        if (byte_if.data != EXT_PREFIX) // E0 carries no key.
                        begin
                            held_code <= byte_if.data;
                            blank     <= 1'b0;
                        end
                    end
                end
                st_wait_break:
                begin
                    if (byte_if.frame_err)
                    begin
                        state <= st_idle; // Lost byte, the break no longer applies.
                    end
                    else if (take_break && (byte_if.data != EXT_PREFIX)
                             && (byte_if.data != BREAK_PREFIX))
                    begin
                        blank <= 1'b1;
                        state <= st_idle;
                    end
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!rst)
        state inside {st_idle, st_pop, st_wait_break});

endmodule

`default_nettype wire

// File: hw/ps2_key_display.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_key_display
    import ps2_pkg::*, disp_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
)
(
    input  logic         clk,
    input  logic         rst,
    input  logic         ps2_clk,
    input  logic         ps2_dat,
    output seg_pattern_t seg_lo,
    output seg_pattern_t seg_hi
);

    scan_code_t held_code;
    logic       blank;

    ps2_byte_if byte_bus ();

    ps2_receiver #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_receiver (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .byte_if (byte_bus.source)
    );

    key_tracker u_tracker (
        .clk       (clk),
        .rst       (rst),
        .byte_if   (byte_bus.sink),
        .held_code (held_code),
        .blank     (blank)
    );

    // Low nibble on the right-hand display.
    seg7_decoder u_seg_lo (
        .digit (held_code[3:0]),
        .blank (blank),
        .seg   (seg_lo)
    );

    seg7_decoder u_seg_hi (
        .digit (held_code[7:4]),
        .blank (blank),
        .seg   (seg_hi)
    );

endmodule

`default_nettype wire

// File: bench/tb_ps2_key_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_key_display
    import ps2_pkg::*, disp_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int PS2_HALF    = 20; // PS/2 clock half-period in clk cycles.
    localparam int FRAME_COUNT = 45;
    // Each frame takes 11 bits of 40 clk cycles plus the settle wait and some slack.
    localparam int WATCHDOG_CYCLES = FRAME_COUNT * (11 * 2 * PS2_HALF + 30) + 1000;

    logic         clk;
    logic         rst;
    logic         ps2_clk;
    logic         ps2_dat;
    seg_pattern_t seg_lo;
    seg_pattern_t seg_hi;

    integer     seed = 32'h1270;
    int         error_count = 0;
    int         check_count = 0;
    scan_code_t model_held;
    logic       model_blank;
    logic       model_wait;

    ps2_key_display #(
        .FIFO_DEPTH (8)
    ) i_dut (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .seg_lo  (seg_lo),
        .seg_hi  (seg_hi)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Inputs change 1 ns after the rising edge.
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Active-low segment table in {dp, g, f, e, d, c, b, a} order.
    function automatic seg_pattern_t hex_to_seg(input hex_digit_t d);
        case (d)
            4'h0:    return 8'hC0;
            4'h1:    return 8'hF9;
            4'h2:    return 8'hA4;
            4'h3:    return 8'hB0;
            4'h4:    return 8'h99;
            4'h5:    return 8'h92;
            4'h6:    return 8'h82;
            4'h7:    return 8'hF8;
            4'h8:    return 8'h80;
            4'h9:    return 8'h90;
            4'hA:    return 8'h88;
            4'hB:    return 8'h83;
            4'hC:    return 8'hC6;
            4'hD:    return 8'hA1;
            4'hE:    return 8'h86;
            default: return 8'h8E;
        endcase
    endfunction

    function automatic seg_pattern_t expected_seg(input hex_digit_t d, input logic blank);
        return blank ? SEG_BLANK : hex_to_seg(d);
    endfunction

    // Applies the make/break rules of scan-code set 2 to one good byte.
    task automatic predict_byte(input scan_code_t code);
        if (model_wait)
        begin
            if (code != EXT_PREFIX && code != BREAK_PREFIX)
            begin
                model_blank = 1'b1;
                model_wait  = 1'b0;
            end
        end
        else if (code == BREAK_PREFIX)
        begin
            model_wait = 1'b1;
        end
        else if (code != EXT_PREFIX)
        begin
            model_held  = code;
            model_blank = 1'b0;
        end
    endtask

    task automatic predict_bad_frame();
        model_wait = 1'b0; // A lost byte cancels a pending break.
    endtask

    task automatic check_seg(input seg_pattern_t actual, input seg_pattern_t expected,
                             input string what);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_display(input string step);
        check_seg(seg_lo, expected_seg(model_held[3:0], model_blank), {step, " seg_lo"});
        check_seg(seg_hi, expected_seg(model_held[7:4], model_blank), {step, " seg_hi"});
    endtask

    // Device side sends the start bit first and the data LSB first.
    task automatic shift_out_frame(input scan_code_t code, input logic flip_parity);
        frame_t frame;
        frame = {1'b1, (~^code) ^ flip_parity, code, 1'b0};
        for (int i = 0; i < 11; i++)
        begin
            ps2_dat = frame[i];
            wait_cycles(PS2_HALF);
            ps2_clk = 1'b0;
            wait_cycles(PS2_HALF);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
    endtask

    task automatic send_frame(input scan_code_t code);
        shift_out_frame(code, 1'b0);
        predict_byte(code);
    endtask

    task automatic send_bad_frame(input scan_code_t code);
        shift_out_frame(code, 1'b1);
        predict_bad_frame();
    endtask

    task automatic send_and_check(input scan_code_t code, input string step);
        send_frame(code);
        wait_cycles(10);
        check_display(step);
    endtask

    task automatic bad_and_check(input scan_code_t code, input string step);
        send_bad_frame(code);
        wait_cycles(10);
        check_display(step);
    endtask

    function automatic scan_code_t random_key();
        scan_code_t code;
        code = $random(seed);
        while (code == BREAK_PREFIX || code == EXT_PREFIX)
        begin
            code = $random(seed);
        end
        return code;
    endfunction

    task automatic test_reset();
        check_seg(seg_lo, SEG_BLANK, "reset seg_lo");
        check_seg(seg_hi, SEG_BLANK, "reset seg_hi");
    endtask

    task automatic test_make_codes();
        for (int i = 0; i < 20; i++)
        begin
            send_and_check(random_key(), $sformatf("make %0d", i));
        end
    endtask

    task automatic test_break();
        send_and_check(8'h1C, "break make");
        send_and_check(BREAK_PREFIX, "break prefix");
        send_and_check(8'h1C, "break code");
        send_and_check(8'h32, "break relight");
    endtask

    task automatic test_extended();
        send_and_check(EXT_PREFIX, "ext prefix");
        send_and_check(8'h75, "ext make");
        send_and_check(EXT_PREFIX, "ext break prefix");
        send_frame(BREAK_PREFIX);
        send_and_check(8'h75, "ext break");
        send_and_check(EXT_PREFIX, "ext relight prefix");
        send_and_check(8'h6B, "ext relight");
    endtask

    task automatic test_bad_frames();
        send_and_check(8'h2B, "bad make");
        send_and_check(BREAK_PREFIX, "bad prefix");
        bad_and_check(8'h2B, "bad after break");
        send_and_check(8'h4D, "bad next make");
        bad_and_check(8'h33, "bad alone");
    endtask

    task automatic test_burst();
        scan_code_t burst [9] = '{8'h16, 8'hF0, 8'h16, 8'hE0, 8'h74, 8'h1E, 8'hF0,
                                   8'h1E, 8'h45};
        foreach (burst[i])
        begin
            send_frame(burst[i]);
        end
        wait_cycles(10);
        check_display("burst final");
    endtask

    initial
    begin
        rst         = 1'b0;
        ps2_clk     = 1'b1;
        ps2_dat     = 1'b1;
        model_held  = '0;
        model_blank = 1'b1;
        model_wait  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        wait_cycles(2);

        test_reset();
        test_make_codes();
        test_break();
        test_extended();
        test_bad_frames();
        test_burst();

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish in time, %0d errors so far", error_count);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hw/ps2_pkg.sv
hw/disp_pkg.sv
hw/ps2_byte_if.sv
hw/seg7_decoder.sv
hw/ps2_receiver.sv
hw/key_tracker.sv
hw/ps2_key_display.sv
bench/tb_ps2_key_display.sv

// File: Bender.yml
package:
  name: ps2_key_display

sources:
  - hw/ps2_pkg.sv
  - hw/disp_pkg.sv
  - hw/ps2_byte_if.sv
  - hw/seg7_decoder.sv
  - hw/ps2_receiver.sv
  - hw/key_tracker.sv
  - hw/ps2_key_display.sv
  - target: test
    files:
      - bench/tb_ps2_key_display.sv
